//--- bench/ecc_tb.sv
`include "ecc_defs.svh"

module ecc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int cycle_limit     = 4000;
    localparam int done_wait_limit = 20;

    logic                      clk;
    logic                      rst;
    logic [3:0]                paddr;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [`ECC_AMBA_WORD-1:0] pwdata;
    logic [`ECC_AMBA_WORD-1:0] prdata;
    logic [`ECC_AMBA_WORD-1:0] data_out;
    logic                      operation_done;
    logic [1:0]                num_of_errors;

    integer seed;
    int     error_count;
    int     op_count;
    int     cycle_count;

    ecc_top i_ecc_top (
        .clk            (clk),
        .rst            (rst),
        .paddr          (paddr),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .data_out       (data_out),
        .operation_done (operation_done),
        .num_of_errors  (num_of_errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // run length guard
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic int code_bits(input ecc_pkg::code_len_t len);
        case (len)
            ecc_pkg::len_8:  return 8;
            ecc_pkg::len_16: return 16;
            default:         return 32;
        endcase
    endfunction

    function automatic int info_bits(input ecc_pkg::code_len_t len);
        case (len)
            ecc_pkg::len_8:  return 4;
            ecc_pkg::len_16: return 11;
            default:         return 26;
        endcase
    endfunction

    function automatic logic [31:0] low_mask(input int width);
        if (width >= 32) begin
            return '1;
        end
        return (32'd1 << width) - 32'd1;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        error_count++;
        $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
    endtask

    task automatic report_problem(input string what);
        error_count++;
        $display("ERROR: %s", what);
    endtask

    // setup phase, access phase, then idle
    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clk);
        paddr   <= addr;
        pwdata  <= data;
        pwrite  <= 1'b1;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // writes control, then counts cycles from the start pulse to done
    task automatic run_op(input ecc_pkg::op_t op, input int exp_latency);
        int latency;
        bit seen;
        latency = 0;
        seen = 0;
        op_count++;
        apb_write(`ECC_ADDR_CTRL, 32'(op));
        while (!seen && latency < done_wait_limit) begin
            @(negedge clk);
            if (operation_done === 1'b1) begin
                seen = 1;
            end else begin
                latency++;
            end
        end
        if (!seen) begin
            report_problem("operation_done never came after the control write");
        end else if (latency != exp_latency) begin
            report_mismatch("done latency", latency, exp_latency);
        end
        @(negedge clk);
        if (operation_done !== 1'b0) begin
            report_problem("operation_done stayed high for more than one cycle");
        end
    endtask

    task automatic check_codeword(input ecc_pkg::code_len_t len, input logic [31:0] data,
                                  input logic [31:0] cw);
        int n;
        int k;
        int p;
        n = code_bits(len);
        k = info_bits(len);
        p = n - k;
        if (((cw >> p) & low_mask(k)) !== (data & low_mask(k))) begin
            report_mismatch("data_out info field", (cw >> p) & low_mask(k), data & low_mask(k));
        end
        if ((cw & ~low_mask(n)) !== 32'd0) begin
            report_mismatch("data_out padding", cw & ~low_mask(n), 32'd0);
        end
        if (^cw !== 1'b0) begin
            report_mismatch("data_out overall parity", 32'(^cw), 32'd0);
        end
    endtask

    task automatic test_encode(input ecc_pkg::code_len_t len, input int count);
        logic [31:0] data;
        for (int i = 0; i < count; i++) begin
            data = $random(seed);
            apb_write(`ECC_ADDR_DATA_IN, data);
            run_op(ecc_pkg::op_encode, 2);
            check_codeword(len, data, data_out);
            if (num_of_errors !== 2'd0) begin
                report_mismatch("num_of_errors", 32'(num_of_errors), 32'd0);
            end
        end
    endtask

    // nbits noise bits at distinct positions inside the code length
    task automatic test_channel(input ecc_pkg::code_len_t len, input int count,
                                input int nbits);
        logic [31:0] data;
        logic [31:0] noise;
        int          n;
        int          pos_a;
        int          pos_b;
        n = code_bits(len);
        for (int i = 0; i < count; i++) begin
            data = $random(seed);
            noise = '0;
            pos_a = $unsigned($random(seed)) % n;
            // first single-bit case hits the overall parity bit
            if (nbits == 1 && i == 0) begin
                pos_a = n - info_bits(len) - 1;
            end
            if (nbits >= 1) begin
                noise[pos_a] = 1'b1;
            end
            if (nbits == 2) begin
                pos_b = pos_a;
                while (pos_b == pos_a) begin
                    pos_b = $unsigned($random(seed)) % n;
                end
                noise[pos_b] = 1'b1;
            end
            apb_write(`ECC_ADDR_DATA_IN, data);
            apb_write(`ECC_ADDR_NOISE, noise);
            run_op(ecc_pkg::op_channel, 4);
            if (nbits < 2 && data_out !== (data & low_mask(info_bits(len)))) begin
                report_mismatch("data_out", data_out, data & low_mask(info_bits(len)));
            end
            if (num_of_errors !== 2'(nbits)) begin
                report_mismatch("num_of_errors", 32'(num_of_errors), nbits);
            end
        end
    endtask

    task automatic test_decode(input ecc_pkg::code_len_t len, input int count);
        logic [31:0] data;
        logic [31:0] cw;
        logic [31:0] exp_info;
        int          pos;
        for (int i = 0; i < count; i++) begin
            data = $random(seed);
            exp_info = data & low_mask(info_bits(len));
            apb_write(`ECC_ADDR_DATA_IN, data);
            run_op(ecc_pkg::op_encode, 2);
            cw = data_out;
            // a clean codeword once per length
            if (i == 0) begin
                apb_write(`ECC_ADDR_DATA_IN, cw);
                run_op(ecc_pkg::op_decode, 2);
                if (data_out !== exp_info) begin
                    report_mismatch("data_out", data_out, exp_info);
                end
                if (num_of_errors !== 2'd0) begin
                    report_mismatch("num_of_errors", 32'(num_of_errors), 32'd0);
                end
            end
            pos = $unsigned($random(seed)) % code_bits(len);
            apb_write(`ECC_ADDR_DATA_IN, cw ^ (32'd1 << pos));
            run_op(ecc_pkg::op_decode, 2);
            if (data_out !== exp_info) begin
                report_mismatch("data_out", data_out, exp_info);
            end
            if (num_of_errors !== 2'd1) begin
                report_mismatch("num_of_errors", 32'(num_of_errors), 32'd1);
            end
        end
    endtask

    task automatic test_registers();
        logic [31:0] data;
        logic [31:0] noise;
        logic [31:0] rd;
        data = $random(seed);
        noise = $random(seed);
        apb_write(`ECC_ADDR_DATA_IN, data);
        apb_write(`ECC_ADDR_NOISE, noise);
        apb_write(`ECC_ADDR_CODEWORD_WIDTH, 32'(ecc_pkg::len_16));
        // op value 3 starts nothing
        apb_write(`ECC_ADDR_CTRL, 32'd3);
        apb_read(`ECC_ADDR_DATA_IN, rd);
        if (rd !== data) begin
            report_mismatch("prdata data_in", rd, data);
        end
        apb_read(`ECC_ADDR_NOISE, rd);
        if (rd !== noise) begin
            report_mismatch("prdata noise", rd, noise);
        end
        apb_read(`ECC_ADDR_CODEWORD_WIDTH, rd);
        if (rd !== 32'(ecc_pkg::len_16)) begin
            report_mismatch("prdata codeword_width", rd, 32'(ecc_pkg::len_16));
        end
        apb_read(`ECC_ADDR_CTRL, rd);
        if (rd !== 32'd3) begin
            report_mismatch("prdata ctrl", rd, 32'd3);
        end
    endtask

    task automatic test_reset();
        logic [31:0] rd;
        apb_write(`ECC_ADDR_CODEWORD_WIDTH, 32'(ecc_pkg::len_32));
        apb_write(`ECC_ADDR_DATA_IN, 32'h0155_aa01);
        run_op(ecc_pkg::op_encode, 2);
        if (data_out === 32'd0) begin
            report_problem("encode result is zero, reset cannot be observed");
        end
        // a second encode is cut off by reset in the cycle its done would rise
        apb_write(`ECC_ADDR_CTRL, 32'(ecc_pkg::op_encode));
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (data_out !== 32'd0) begin
            report_mismatch("data_out in reset", data_out, 32'd0);
        end
        if (operation_done !== 1'b0) begin
            report_mismatch("operation_done in reset", 32'(operation_done), 32'd0);
        end
        apb_read(`ECC_ADDR_DATA_IN, rd);
        if (rd !== 32'd0) begin
            report_mismatch("prdata data_in in reset", rd, 32'd0);
        end
        repeat (4) @(posedge clk);
        rst <= 1'b1;
    endtask

    initial begin
        rst = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        seed = 86;
        error_count = 0;
        op_count = 0;
        cycle_count = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        if (data_out !== 32'd0) begin
            report_mismatch("data_out after reset", data_out, 32'd0);
        end
        if (operation_done !== 1'b0) begin
            report_mismatch("operation_done after reset", 32'(operation_done), 32'd0);
        end

        for (int l = 0; l < 3; l++) begin
            apb_write(`ECC_ADDR_CODEWORD_WIDTH, l);
            test_encode(ecc_pkg::code_len_t'(l), 10);
            test_channel(ecc_pkg::code_len_t'(l), 6, 0);
            test_channel(ecc_pkg::code_len_t'(l), 12, 1);
            test_channel(ecc_pkg::code_len_t'(l), 10, 2);
            test_decode(ecc_pkg::code_len_t'(l), 8);
        end
        test_registers();
        test_reset();

        $display("operations: %0d, errors: %0d", op_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+src
src/ecc_pkg.sv
src/ecc_cmd_if.sv
src/ecc_apb_regs.sv
src/gf2_mat_mult.sv
src/hamming_enc_stage1.sv
src/hamming_decoder.sv
src/ecc_datapath.sv
src/ecc_top.sv
bench/ecc_tb.sv

//--- src/ecc_apb_regs.sv
`include "ecc_defs.svh"

module ecc_apb_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [3:0]                 paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [`ECC_AMBA_WORD-1:0]  pwdata,
    output logic [`ECC_AMBA_WORD-1:0]  prdata,
    ecc_cmd_if.regs                    cmd
);

    logic wr_en;

    // no wait states, so every access phase completes
    assign wr_en = psel && penable && pwrite;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cmd.start    <= 1'b0;
            cmd.op       <= ecc_pkg::op_encode;
            cmd.code_len <= ecc_pkg::len_8;
            cmd.data     <= '0;
            cmd.noise    <= '0;
        end else begin
            // writing control launches the operation on the next cycle
            cmd.start <= wr_en && (paddr == `ECC_ADDR_CTRL);
            if (wr_en) begin
                case (paddr)
                    `ECC_ADDR_CTRL: begin
                        cmd.op <= ecc_pkg::op_t'(pwdata[1:0]);
                    end
                    `ECC_ADDR_DATA_IN: begin
                        cmd.data.codeword <= pwdata;
                    end
                    `ECC_ADDR_CODEWORD_WIDTH: begin
                        cmd.code_len <= ecc_pkg::code_len_t'(pwdata[1:0]);
                    end
                    `ECC_ADDR_NOISE: begin
                        cmd.noise <= pwdata;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // read mux, unmapped offsets return zero
    always_comb begin
        case (paddr)
            `ECC_ADDR_CTRL: begin
                prdata = `ECC_AMBA_WORD'(cmd.op);
            end
            `ECC_ADDR_DATA_IN: begin
                prdata = cmd.data.codeword;
            end
            `ECC_ADDR_CODEWORD_WIDTH: begin
                prdata = `ECC_AMBA_WORD'(cmd.code_len);
            end
            `ECC_ADDR_NOISE: begin
                prdata = cmd.noise;
            end
            default: begin
                prdata = '0;
            end
        endcase
    end

endmodule

//--- src/ecc_cmd_if.sv
`include "ecc_defs.svh"

// one command from the register block to the datapath
interface ecc_cmd_if;

    // single cycle, one clock after the control write
    logic                       start;
    ecc_pkg::op_t               op;
    ecc_pkg::code_len_t         code_len;
    ecc_pkg::data_word_u        data;
    logic [`ECC_AMBA_WORD-1:0]  noise;

    modport regs (
        output start, op, code_len, data, noise
    );

    modport datapath (
        input start, op, code_len, data, noise
    );

endinterface

//--- src/ecc_datapath.sv
`include "ecc_defs.svh"

module ecc_datapath (
    input  logic                      clk,
    input  logic                      rst,
    ecc_cmd_if.datapath               cmd,
    output logic [`ECC_AMBA_WORD-1:0] data_out,
    output logic                      operation_done,
    output logic [1:0]                num_of_errors
);

    logic                           enc_start;
    logic [`ECC_CODEWORD_WIDTH-1:0] enc1_cw;
    logic                           enc1_valid;
    ecc_pkg::op_t                   enc1_op;
    ecc_pkg::code_len_t             enc1_len;
    logic [`ECC_CODEWORD_WIDTH-1:0] enc1_full;
    logic                           enc_done;
    logic [`ECC_CODEWORD_WIDTH-1:0] enc_res;
    logic                           chan_valid;
    logic [`ECC_CODEWORD_WIDTH-1:0] chan_cw;
    ecc_pkg::code_len_t             chan_len;
    logic                           dec_in_valid;
    logic [`ECC_CODEWORD_WIDTH-1:0] dec_cw;
    ecc_pkg::code_len_t             dec_len;
    logic [`ECC_INFO_WIDTH-1:0]     dec_info;
    logic [1:0]                     dec_nerr;
    logic                           dec_valid;
    logic                           from_dec;
    logic                           from_dec_q;

    assign enc_start = cmd.start &&
                       (cmd.op == ecc_pkg::op_encode || cmd.op == ecc_pkg::op_channel);

    hamming_enc_stage1 u_enc (
        .clk       (clk),
        .rst       (rst),
        .info      (cmd.data.info_view.info),
        .code_len  (cmd.code_len),
        .in_valid  (enc_start),
        .codeword  (enc1_cw),
        .out_valid (enc1_valid)
    );

    // overall parity goes into the top parity bit of the selected length
    always_comb begin
        enc1_full = enc1_cw;
        case (enc1_len)
            ecc_pkg::len_8:  enc1_full[3] = ^enc1_cw;
            ecc_pkg::len_16: enc1_full[4] = ^enc1_cw;
            ecc_pkg::len_32: enc1_full[5] = ^enc1_cw;
            default: begin
            end
        endcase
    end

    // op and length travel beside the item in stage 1
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            enc1_op    <= ecc_pkg::op_encode;
            enc1_len   <= ecc_pkg::len_8;
            enc_done   <= 1'b0;
            chan_valid <= 1'b0;
            enc_res    <= '0;
            from_dec_q <= 1'b0;
        end else begin
            if (enc_start) begin
                enc1_op  <= cmd.op;
                enc1_len <= cmd.code_len;
            end
            enc_done   <= enc1_valid && (enc1_op == ecc_pkg::op_encode);
            chan_valid <= enc1_valid && (enc1_op == ecc_pkg::op_channel);
            // encode results are kept apart so channel traffic cannot disturb them
            if (enc1_valid && enc1_op == ecc_pkg::op_encode) begin
                enc_res <= enc1_full;
            end
            from_dec_q <= from_dec;
        end
    end

    // noise injection for channel items
    always_ff @(posedge clk) begin
        if (enc1_valid && enc1_op == ecc_pkg::op_channel) begin
            chan_cw  <= enc1_full ^ cmd.noise;
            chan_len <= enc1_len;
        end
    end

    // a channel item already in flight takes the decoder before a new decode
    assign dec_in_valid = chan_valid || (cmd.start && cmd.op == ecc_pkg::op_decode);
    assign dec_cw       = chan_valid ? chan_cw : cmd.data.codeword;
    assign dec_len      = chan_valid ? chan_len : cmd.code_len;

    hamming_decoder u_dec (
        .clk        (clk),
        .rst        (rst),
        .codeword   (dec_cw),
        .code_len   (dec_len),
        .in_valid   (dec_in_valid),
        .info       (dec_info),
        .num_errors (dec_nerr),
        .out_valid  (dec_valid)
    );

    // the source of the last result is held until the next done
    assign from_dec       = dec_valid || (!enc_done && from_dec_q);
    assign operation_done = dec_valid || enc_done;
    assign data_out       = from_dec ? `ECC_AMBA_WORD'(dec_info) : enc_res;
    assign num_of_errors  = from_dec ? dec_nerr : 2'd0;

endmodule

//--- src/ecc_defs.svh
`ifndef ECC_DEFS_SVH
`define ECC_DEFS_SVH

// bus and code geometry, sized for the widest code (32,26)
`define ECC_AMBA_WORD       32
`define ECC_CODEWORD_WIDTH  32
`define ECC_INFO_WIDTH      26
// hamming rows plus the overall parity row
`define ECC_PARITY_WIDTH    6

// apb register offsets
`define ECC_ADDR_CTRL            4'h0
`define ECC_ADDR_DATA_IN         4'h4
`define ECC_ADDR_CODEWORD_WIDTH  4'h8
`define ECC_ADDR_NOISE           4'hC

`endif

//--- src/ecc_pkg.sv
`include "ecc_defs.svh"

package ecc_pkg;

    typedef enum logic [1:0] {
        op_encode  = 2'd0,
        op_decode  = 2'd1,
        op_channel = 2'd2
    } op_t;

    typedef enum logic [1:0] {
        len_8  = 2'd0,
        len_16 = 2'd1,
        len_32 = 2'd2
    } code_len_t;

    // the data register is a codeword when decoding and an info field when encoding
    typedef union packed {
        logic [`ECC_AMBA_WORD-1:0] codeword;
        struct packed {
            logic [`ECC_AMBA_WORD-`ECC_INFO_WIDTH-1:0] unused;
            logic [`ECC_INFO_WIDTH-1:0]                info;
        } info_view;
    } data_word_u;

    // hamming column of info bit j: the j-th value from 3 upward that is not a power of two
    function automatic logic [`ECC_PARITY_WIDTH-2:0] info_col(input int j);
        int                          n;
        logic [`ECC_PARITY_WIDTH-2:0] c;
        n = 0;
        c = '0;
        for (int v = 3; v < (1 << (`ECC_PARITY_WIDTH - 1)); v++) begin
            if ((v & (v - 1)) != 0) begin
                if (n == j) begin
                    c = (`ECC_PARITY_WIDTH-1)'(v);
                end
                n++;
            end
        end
        return c;
    endfunction

endpackage

//--- src/ecc_top.sv
`include "ecc_defs.svh"

module ecc_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [3:0]                paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`ECC_AMBA_WORD-1:0] pwdata,
    output logic [`ECC_AMBA_WORD-1:0] prdata,
    output logic [`ECC_AMBA_WORD-1:0] data_out,
    output logic                      operation_done,
    output logic [1:0]                num_of_errors
);

    ecc_cmd_if cmd_bus ();

    ecc_apb_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .cmd     (cmd_bus.regs)
    );

    ecc_datapath u_datapath (
        .clk            (clk),
        .rst            (rst),
        .cmd            (cmd_bus.datapath),
        .data_out       (data_out),
        .operation_done (operation_done),
        .num_of_errors  (num_of_errors)
    );

endmodule

//--- src/gf2_mat_mult.sv
// product of a matrix and a column vector over GF(2)
// row r of the matrix sits at mat[r*cols +: cols] and yields prod[r]
module gf2_mat_mult #(
    parameter int rows = 6,
    parameter int cols = 26
) (
    input  logic [rows*cols-1:0]  mat,
    input  logic [cols-1:0]       vec,
    output logic [rows-1:0]       prod
);

    always_comb begin
        for (int r = 0; r < rows; r++) begin
            // and then xor reduce
            prod[r] = ^(mat[r*cols +: cols] & vec);
        end
    end

endmodule

//--- src/hamming_decoder.sv
`include "ecc_defs.svh"

module hamming_decoder (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [`ECC_CODEWORD_WIDTH-1:0] codeword,
    input  ecc_pkg::code_len_t             code_len,
    input  logic                           in_valid,
    output logic [`ECC_INFO_WIDTH-1:0]     info,
    output logic [1:0]                     num_errors,
    output logic                           out_valid
);

    localparam int ham_rows = `ECC_PARITY_WIDTH - 1;
    localparam int cw_bits  = `ECC_CODEWORD_WIDTH;
    localparam int mat_bits = ham_rows * cw_bits;

    // hamming rows over the whole codeword: p check bits, overall bit, k info bits
    // the overall bit has an all zero column here, it is covered by the parity xor
    function automatic logic [mat_bits-1:0] full_matrix(input int p, input int k);
        logic [mat_bits-1:0] m;
        logic [ham_rows-1:0] c;
        m = '0;
        for (int q = 0; q < cw_bits; q++) begin
            c = '0;
            if (q < p) begin
                c = ham_rows'(1 << q);
            end else if (q > p && q <= p + k) begin
                c = ecc_pkg::info_col(q - p - 1);
            end
            for (int i = 0; i < ham_rows; i++) begin
                m[i*cw_bits + q] = c[i];
            end
        end
        return m;
    endfunction

    localparam logic [mat_bits-1:0] h_len8  = full_matrix(3, 4);
    localparam logic [mat_bits-1:0] h_len16 = full_matrix(4, 11);
    localparam logic [mat_bits-1:0] h_len32 = full_matrix(5, 26);

    function automatic logic [mat_bits-1:0] matrix_for(input ecc_pkg::code_len_t len);
        case (len)
            ecc_pkg::len_8:  return h_len8;
            ecc_pkg::len_16: return h_len16;
            ecc_pkg::len_32: return h_len32;
            default:         return '0;
        endcase
    endfunction

    logic [cw_bits-1:0]        cw_masked;
    logic [ham_rows-1:0]       syndrome;
    logic [mat_bits-1:0]       s1_mat;
    logic [mat_bits-1:0]       s2_mat;
    logic                      s1_valid;
    logic [ham_rows-1:0]       s1_syndrome;
    logic                      s1_odd;
    logic [cw_bits-1:0]        s1_cw;
    ecc_pkg::code_len_t        s1_len;
    logic [cw_bits-1:0]        flip;
    logic [cw_bits-1:0]        corrected;
    logic [`ECC_INFO_WIDTH-1:0] info_next;
    logic [1:0]                nerr_next;

    // bits above the selected length do not take part
    always_comb begin
        case (code_len)
            ecc_pkg::len_8:  cw_masked = codeword & cw_bits'(8'hff);
            ecc_pkg::len_16: cw_masked = codeword & cw_bits'(16'hffff);
            ecc_pkg::len_32: cw_masked = codeword;
            default:         cw_masked = '0;
        endcase
    end

    assign s1_mat = matrix_for(code_len);

    gf2_mat_mult #(
        .rows (ham_rows),
        .cols (cw_bits)
    ) u_syndrome (
        .mat  (s1_mat),
        .vec  (cw_masked),
        .prod (syndrome)
    );

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_syndrome <= syndrome;
            s1_odd      <= ^cw_masked;
            s1_cw       <= cw_masked;
            s1_len      <= code_len;
        end
    end

    assign s2_mat = matrix_for(s1_len);

    always_comb begin
        logic [ham_rows-1:0] col;
        // single error: flip the bit whose column matches the syndrome
        for (int q = 0; q < cw_bits; q++) begin
            for (int i = 0; i < ham_rows; i++) begin
                col[i] = s2_mat[i*cw_bits + q];
            end
            flip[q] = s1_odd && (s1_syndrome != '0) && (col == s1_syndrome);
        end
        corrected = s1_cw ^ flip;

        case (s1_len)
            ecc_pkg::len_8:  info_next = `ECC_INFO_WIDTH'(corrected[7:4]);
            ecc_pkg::len_16: info_next = `ECC_INFO_WIDTH'(corrected[15:5]);
            ecc_pkg::len_32: info_next = corrected[31:6];
            default:         info_next = '0;
        endcase

        // odd parity means one error, even parity with a syndrome means two
        if (s1_odd) begin
            nerr_next = 2'd1;
        end else if (s1_syndrome != '0) begin
            nerr_next = 2'd2;
        end else begin
            nerr_next = 2'd0;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid  <= 1'b0;
            info       <= '0;
            num_errors <= 2'd0;
        end else begin
            out_valid <= s1_valid;
            if (s1_valid) begin
                info       <= info_next;
                num_errors <= nerr_next;
            end
        end
    end

endmodule

//--- src/hamming_enc_stage1.sv
`include "ecc_defs.svh"

module hamming_enc_stage1 (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [`ECC_INFO_WIDTH-1:0]     info,
    input  ecc_pkg::code_len_t             code_len,
    input  logic                           in_valid,
    output logic [`ECC_CODEWORD_WIDTH-1:0] codeword,
    output logic                           out_valid
);

    localparam int mat_bits = `ECC_PARITY_WIDTH * `ECC_INFO_WIDTH;

    // info part of the parity check matrix, padded to 6 x 26
    // the overall parity row (row 5) stays zero, it is filled in later
    function automatic logic [mat_bits-1:0] info_matrix(input int k);
        logic [mat_bits-1:0]           m;
        logic [`ECC_PARITY_WIDTH-2:0]  c;
        m = '0;
        for (int j = 0; j < k; j++) begin
            c = ecc_pkg::info_col(j);
            for (int i = 0; i < `ECC_PARITY_WIDTH - 1; i++) begin
                m[i*`ECC_INFO_WIDTH + j] = c[i];
            end
        end
        return m;
    endfunction

    localparam logic [mat_bits-1:0] h_len8  = info_matrix(4);
    localparam logic [mat_bits-1:0] h_len16 = info_matrix(11);
    localparam logic [mat_bits-1:0] h_len32 = info_matrix(26);

    logic [mat_bits-1:0]            mat_sel;
    logic [`ECC_PARITY_WIDTH-1:0]   parity;
    logic [`ECC_CODEWORD_WIDTH-1:0] cw_next;

    always_comb begin
        case (code_len)
            ecc_pkg::len_8:  mat_sel = h_len8;
            ecc_pkg::len_16: mat_sel = h_len16;
            ecc_pkg::len_32: mat_sel = h_len32;
            default:         mat_sel = '0;
        endcase
    end

    gf2_mat_mult #(
        .rows (`ECC_PARITY_WIDTH),
        .cols (`ECC_INFO_WIDTH)
    ) u_parity (
        .mat  (mat_sel),
        .vec  (info),
        .prod (parity)
    );

    // info above parity, zero padding on top
    // the top parity bit of each length comes out zero from the padded matrix
    always_comb begin
        case (code_len)
            ecc_pkg::len_8: begin
                cw_next = `ECC_CODEWORD_WIDTH'({info[3:0], parity[3:0]});
            end
            ecc_pkg::len_16: begin
                cw_next = `ECC_CODEWORD_WIDTH'({info[10:0], parity[4:0]});
            end
            ecc_pkg::len_32: begin
                cw_next = {info, parity};
            end
            default: begin
                cw_next = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            codeword <= cw_next;
        end
    end

endmodule
